// File: vec_alu_top.f
src/alu_data_pkg.sv
src/alu_isa_pkg.sv
src/alu_decode.sv
src/alu_execute.sv
src/alu_result.sv
src/vec_alu_top.sv
test/vec_alu_tb.sv

// File: Bender.yml
package:
  name: vec_alu

sources:
  - src/alu_data_pkg.sv
  - src/alu_isa_pkg.sv
  - src/alu_decode.sv
  - src/alu_execute.sv
  - src/alu_result.sv
  - src/vec_alu_top.sv
  - target: test
    files:
      - test/vec_alu_tb.sv

// File: test/vec_alu_tb.sv
/*
 * Testbench for the vector ALU stage
 * Random handshakes on every port, with a reference model checked each cycle
 */
module vec_alu_tb import alu_data_pkg::*; import alu_isa_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int VSIZE = 4;
	localparam int N_INST = 50;

	logic i_clk = 1'b0;
	logic i_rst;
	alu_inst_t i_op;
	logic i_op_rdy;
	logic o_op_ack;
	sram_word_t i_sramrd0 [VSIZE];
	logic i_sramrd0_rdy;
	logic o_sramrd0_ack;
	sram_word_t i_sramrd1 [VSIZE];
	logic i_sramrd1_rdy;
	logic o_sramrd1_ack;
	lane_t i_rdata [VSIZE];
	sram_word_t o_dramwd [VSIZE];
	logic o_dramwd_rdy;
	logic i_dramwd_ack;
	logic o_reg_we;
	logic [SRAM_ABW-1:0] o_reg_waddr;
	lane_t o_wdata [VSIZE];
	logic o_tbuf_we;
	logic o_inst_commit;

	integer seed;
	int errors = 0;
	int n_issued = 0;
	int n_commits = 0;
	string test_name = "init";

	// Writes expected one cycle after an ack
	logic pend_reg = 1'b0;
	logic pend_temp = 1'b0;
	logic [SRAM_ABW-1:0] pend_waddr;
	lane_t pend_wdata [VSIZE];
	logic prev_rst = 1'b1;

	alu_opcode_e arith_ops [4] = '{OP_ADD, OP_SUB, OP_NORM1, OP_MAC};
	alu_opcode_e all_ops [5] = '{OP_ADD, OP_SUB, OP_NORM1, OP_MAC, OP_LOGIC};
	logic [4:0] logic_fns [4] = '{5'd0, 5'd2, 5'd3, 5'd5};

	always #20 i_clk = ~i_clk;

	vec_alu_top #(.VSIZE(VSIZE)) vec_alu_top_inst (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_op          (i_op),
		.i_op_rdy      (i_op_rdy),
		.o_op_ack      (o_op_ack),
		.i_sramrd0     (i_sramrd0),
		.i_sramrd0_rdy (i_sramrd0_rdy),
		.o_sramrd0_ack (o_sramrd0_ack),
		.i_sramrd1     (i_sramrd1),
		.i_sramrd1_rdy (i_sramrd1_rdy),
		.o_sramrd1_ack (o_sramrd1_ack),
		.i_rdata       (i_rdata),
		.o_dramwd      (o_dramwd),
		.o_dramwd_rdy  (o_dramwd_rdy),
		.i_dramwd_ack  (i_dramwd_ack),
		.o_reg_we      (o_reg_we),
		.o_reg_waddr   (o_reg_waddr),
		.o_wdata       (o_wdata),
		.o_tbuf_we     (o_tbuf_we),
		.o_inst_commit (o_inst_commit)
	);

	// ==============================
	// Reference model
	// ==============================

	function automatic logic uses_port(input alu_inst_t op, input alu_src_e port);
		return (op.src_a == port) || (op.src_b == port) || (op.src_c == port);
	endfunction

	function automatic lane_t operand_value(input alu_src_e src, input lane_t cval,
		input lane_t rd, input sram_word_t s0, input sram_word_t s1);
		case (src)
			SRC_CONST: return cval;
			SRC_REG:   return rd;
			SRC_SRAM0: return {{(TDBW-DBW){s0[DBW-1]}}, s0};
			SRC_SRAM1: return {{(TDBW-DBW){s1[DBW-1]}}, s1};
			default:   return '0;
		endcase
	endfunction

	function automatic lane_t expected_lane(input alu_inst_t op, input lane_t rd,
		input sram_word_t s0, input sram_word_t s1);
		lane_t a;
		lane_t b;
		lane_t c;
		lane_t d;
		lane_t t;
		logic signed [DBW-1:0] bl;
		logic signed [DBW-1:0] cl;
		a = operand_value(op.src_a, op.const_a, rd, s0, s1);
		b = operand_value(op.src_b, op.const_b, rd, s0, s1);
		c = operand_value(op.src_c, op.const_c, rd, s0, s1);
		bl = b[DBW-1:0];
		cl = c[DBW-1:0];
		d = b - c;
		case (op.opcode)
			OP_ADD:   t = b + c;
			OP_SUB:   t = d;
			OP_NORM1: t = (d < 0) ? -d : d;
			OP_MAC:   t = bl * cl;
			OP_LOGIC: begin
				case (op.shamt)
					5'd0:    return (a == 0) ? b : c;
					5'd2:    return (b >= c) ? b : c;
					5'd3:    return (b <= c) ? b : c;
					default: return '0;
				endcase
			end
			default:  return '0;
		endcase
		return a + (t >>> op.shamt);
	endfunction

	function automatic sram_word_t expected_dram(input lane_t v, input logic [1:0] code);
		lane_t s;
		s = v >>> (2 * code);
		return s[DBW-1:0];
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// ==============================
	// Compare process
	// ==============================

	always @(negedge i_clk) begin
		logic req0;
		logic req1;
		logic ready;
		logic exp_ack;
		lane_t lane_val;
		// Registered outputs reflect the previous cycle's ack
		check_value("reg_we", pend_reg && !prev_rst, o_reg_we);
		check_value("tbuf_we", pend_temp && !prev_rst, o_tbuf_we);
		if (pend_reg || pend_temp) begin
			check_value("reg_waddr", pend_waddr, o_reg_waddr);
			for (int i = 0; i < VSIZE; i++)
				check_value("wdata", pend_wdata[i], o_wdata[i]);
		end
		req0 = uses_port(i_op, SRC_SRAM0);
		req1 = uses_port(i_op, SRC_SRAM1);
		ready = i_op_rdy && (!req0 || i_sramrd0_rdy) && (!req1 || i_sramrd1_rdy);
		exp_ack = ready && ((i_op.to_dram == 2'd3) || i_dramwd_ack);
		check_value("op_ack", exp_ack, o_op_ack);
		check_value("dramwd_rdy", ready && (i_op.to_dram != 2'd3), o_dramwd_rdy);
		check_value("sramrd0_ack", exp_ack && req0, o_sramrd0_ack);
		check_value("sramrd1_ack", exp_ack && req1, o_sramrd1_ack);
		check_value("inst_commit", exp_ack, o_inst_commit);
		for (int i = 0; i < VSIZE; i++) begin
			lane_val = expected_lane(i_op, i_rdata[i], i_sramrd0[i], i_sramrd1[i]);
			pend_wdata[i] = lane_val;
			if (o_dramwd_rdy && i_dramwd_ack)
				check_value("dramwd", expected_dram(lane_val, i_op.to_dram), o_dramwd[i]);
		end
		pend_reg = exp_ack && i_op.to_reg;
		pend_temp = exp_ack && i_op.to_temp;
		pend_waddr = i_op.reg_waddr;
		prev_rst = i_rst;
		if (o_inst_commit)
			n_commits++;
	end

	// ==============================
	// Stimulus
	// ==============================

	task automatic random_inst(output alu_inst_t op, input alu_opcode_e opc,
		input logic [2:0] src_mask, input logic [1:0] dram);
		logic [31:0] r;
		r = $random(seed);
		op.opcode = opc;
		op.shamt = r[4:0];
		op.src_a = alu_src_e'(r[7:5] & src_mask);
		op.src_b = alu_src_e'(r[10:8] & src_mask);
		op.src_c = alu_src_e'(r[13:11] & src_mask);
		op.to_reg = r[14];
		op.to_temp = r[15];
		op.reg_waddr = r[23:16];
		op.to_dram = dram;
		op.const_a = $random(seed);
		op.const_b = $random(seed);
		op.const_c = $random(seed);
	endtask

	// Holds the instruction until the DUT acks it
	task automatic run_inst(input string name, input alu_inst_t op);
		logic [31:0] r;
		logic rdy0;
		logic rdy1;
		logic done;
		@(posedge i_clk);
		test_name = name;
		i_op <= op;
		i_op_rdy <= 1'b1;
		for (int i = 0; i < VSIZE; i++) begin
			r = $random(seed);
			i_sramrd0[i] <= r[15:0];
			i_sramrd1[i] <= r[31:16];
			i_rdata[i] <= $random(seed);
		end
		done = 1'b0;
		while (!done) begin
			r = $random(seed);
			// Source rdy stays up once raised
			rdy0 = i_sramrd0_rdy | r[0];
			rdy1 = i_sramrd1_rdy | r[1];
			i_sramrd0_rdy <= rdy0;
			i_sramrd1_rdy <= rdy1;
			i_dramwd_ack <= r[2] && (op.to_dram != 2'd3) &&
				(!uses_port(op, SRC_SRAM0) || rdy0) && (!uses_port(op, SRC_SRAM1) || rdy1);
			@(negedge i_clk);
			done = o_op_ack;
			@(posedge i_clk);
		end
		i_op_rdy <= 1'b0;
		i_sramrd0_rdy <= 1'b0;
		i_sramrd1_rdy <= 1'b0;
		i_dramwd_ack <= 1'b0;
		n_issued++;
	endtask

	initial begin
		alu_inst_t op;
		logic [31:0] r;
		seed = 32'h622f;
		i_rst = 1'b1;
		i_op = '0;
		i_op_rdy = 1'b0;
		i_sramrd0_rdy = 1'b0;
		i_sramrd1_rdy = 1'b0;
		i_dramwd_ack = 1'b0;
		i_sramrd0 = '{default: '0};
		i_sramrd1 = '{default: '0};
		i_rdata = '{default: '0};
		repeat (2) @(posedge i_clk);
		i_rst <= 1'b0;

		foreach (arith_ops[k]) begin
			repeat (4) begin
				random_inst(op, arith_ops[k], 3'd1, 2'd3);
				run_inst("arith", op);
			end
		end
		foreach (logic_fns[k]) begin
			for (int j = 0; j < 2; j++) begin
				random_inst(op, OP_LOGIC, 3'd1, 2'd3);
				op.shamt = logic_fns[k];
				if (j == 0) begin
					op.src_a = SRC_CONST;
					op.const_a = '0;
				end
				run_inst("logic", op);
			end
		end
		repeat (12) begin
			r = $random(seed);
			random_inst(op, all_ops[r[2:0] % 5], 3'd3, 2'd3);
			run_inst("sram", op);
		end
		for (int d = 0; d < 3; d++) begin
			repeat (3) begin
				r = $random(seed);
				random_inst(op, all_ops[r[2:0] % 5], 3'd3, d[1:0]);
				run_inst("dram", op);
			end
		end
		repeat (4) begin
			random_inst(op, OP_ADD, 3'd3, 2'd3);
			op.to_temp = 1'b1;
			run_inst("temp", op);
		end

		// Reset rises with an instruction that is acked in its first cycle
		random_inst(op, OP_MAC, 3'd1, 2'd3);
		op.to_reg = 1'b1;
		op.to_temp = 1'b1;
		fork
			run_inst("reset", op);
			begin
				@(posedge i_clk);
				i_rst <= 1'b1;
				repeat (2) @(negedge i_clk);
				check_value("we after reset", 2'b00, {o_reg_we, o_tbuf_we});
				@(posedge i_clk);
				i_rst <= 1'b0;
			end
		join

		repeat (3) @(posedge i_clk);
		check_value("commit count", n_issued, n_commits);
		$display("Run complete: %0d instructions, %0d commits, %0d errors",
			n_issued, n_commits, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog, 50 cycles per instruction
	initial begin
		#(N_INST * 50 * 40);
		$display("Timeout: the instructions did not all complete in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: src/vec_alu_top.sv
/*
 * Lane-parallel vector ALU stage
 */
module vec_alu_top import alu_data_pkg::*; import alu_isa_pkg::*; #(
	parameter int VSIZE = 4
) (
	input  logic                i_clk,
	input  logic                i_rst,
	input  alu_inst_t           i_op,
	input  logic                i_op_rdy,
	output logic                o_op_ack,
	input  sram_word_t          i_sramrd0 [VSIZE],
	input  logic                i_sramrd0_rdy,
	output logic                o_sramrd0_ack,
	input  sram_word_t          i_sramrd1 [VSIZE],
	input  logic                i_sramrd1_rdy,
	output logic                o_sramrd1_ack,
	input  lane_t               i_rdata [VSIZE],
	output sram_word_t          o_dramwd [VSIZE],
	output logic                o_dramwd_rdy,
	input  logic                i_dramwd_ack,
	output logic                o_reg_we,
	output logic [SRAM_ABW-1:0] o_reg_waddr,
	output lane_t               o_wdata [VSIZE],
	output logic                o_tbuf_we,
	output logic                o_inst_commit
);

	alu_ctrl_t ctrl;
	logic      commit;
	lane_t     result [VSIZE];

	alu_decode u_decode (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_op          (i_op),
		.i_op_rdy      (i_op_rdy),
		.o_op_ack      (o_op_ack),
		.i_sramrd0_rdy (i_sramrd0_rdy),
		.o_sramrd0_ack (o_sramrd0_ack),
		.i_sramrd1_rdy (i_sramrd1_rdy),
		.o_sramrd1_ack (o_sramrd1_ack),
		.o_dramwd_rdy  (o_dramwd_rdy),
		.i_dramwd_ack  (i_dramwd_ack),
		.o_ctrl        (ctrl),
		.o_commit      (commit)
	);

	alu_execute #(.VSIZE(VSIZE)) u_execute (
		.i_ctrl    (ctrl),
		.i_rdata   (i_rdata),
		.i_sramrd0 (i_sramrd0),
		.i_sramrd1 (i_sramrd1),
		.o_result  (result)
	);

	alu_result #(.VSIZE(VSIZE)) u_result (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_ctrl      (ctrl),
		.i_commit    (commit),
		.i_result    (result),
		.o_dramwd    (o_dramwd),
		.o_reg_we    (o_reg_we),
		.o_reg_waddr (o_reg_waddr),
		.o_wdata     (o_wdata),
		.o_tbuf_we   (o_tbuf_we)
	);

	assign o_inst_commit = commit;

endmodule

// File: src/alu_result.sv
/*
 * Vector ALU result stage
 * Scales results for DRAM and registers the register and temp buffer writes
 */
module alu_result import alu_data_pkg::*; import alu_isa_pkg::*; #(
	parameter int VSIZE = 4
) (
	input  logic                i_clk,
	input  logic                i_rst,
	input  alu_ctrl_t           i_ctrl,
	input  logic                i_commit,
	input  lane_t               i_result [VSIZE],
	output sram_word_t          o_dramwd [VSIZE],
	output logic                o_reg_we,
	output logic [SRAM_ABW-1:0] o_reg_waddr,
	output lane_t               o_wdata [VSIZE],
	output logic                o_tbuf_we
);

	logic [2:0] dram_shift;

	// ==============================
	// DRAM word
	// ==============================

	// Scale by 0, 2 or 4 bits
	assign dram_shift = {i_ctrl.to_dram, 1'b0};

	always_comb begin
		for (int i = 0; i < VSIZE; i++) begin
			o_dramwd[i] = sram_word_t'(i_result[i] >>> dram_shift);
		end
	end

	// ==============================
	// Write register
	// ==============================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_reg_we  <= 1'b0;
			o_tbuf_we <= 1'b0;
		end else begin
			o_reg_we  <= i_commit && i_ctrl.to_reg;
			o_tbuf_we <= i_commit && i_ctrl.to_temp;
		end
	end

	// Shared write data for the register file and the temp buffer
	always_ff @(posedge i_clk) begin
		if (i_commit) begin
			o_reg_waddr <= i_ctrl.reg_waddr;
			o_wdata     <= i_result;
		end
	end

endmodule

// File: src/alu_execute.sv
/*
 * Vector ALU execute
 * Per-lane operand select and the add, sub, 1-norm, MAC and logic operations
 */
module alu_execute import alu_data_pkg::*; import alu_isa_pkg::*; #(
	parameter int VSIZE = 4
) (
	input  alu_ctrl_t  i_ctrl,
	input  lane_t      i_rdata [VSIZE],
	input  sram_word_t i_sramrd0 [VSIZE],
	input  sram_word_t i_sramrd1 [VSIZE],
	output lane_t      o_result [VSIZE]
);

	// SRAM words are signed and widen to the lane
	function automatic lane_t select_operand(
		input alu_src_e   src,
		input lane_t      cval,
		input lane_t      rdata,
		input sram_word_t srd0,
		input sram_word_t srd1
	);
		case (src)
			SRC_CONST: return cval;
			SRC_REG:   return rdata;
			SRC_SRAM0: return lane_t'($signed(srd0));
			SRC_SRAM1: return lane_t'($signed(srd1));
			default:   return '0;
		endcase
	endfunction

	// ==============================
	// Lane datapath
	// ==============================

	for (genvar gi = 0; gi < VSIZE; gi++) begin : g_lane
		lane_t op_a;
		lane_t op_b;
		lane_t op_c;
		lane_t sum_bc;
		lane_t diff_bc;
		lane_t abs_bc;
		lane_t prod_bc;
		lane_t logic_out;
		lane_t lane_res;

		always_comb begin
			op_a = select_operand(i_ctrl.src_a, i_ctrl.const_a, i_rdata[gi],
				i_sramrd0[gi], i_sramrd1[gi]);
			op_b = select_operand(i_ctrl.src_b, i_ctrl.const_b, i_rdata[gi],
				i_sramrd0[gi], i_sramrd1[gi]);
			op_c = select_operand(i_ctrl.src_c, i_ctrl.const_c, i_rdata[gi],
				i_sramrd0[gi], i_sramrd1[gi]);
		end

		always_comb begin
			sum_bc  = op_b + op_c;
			diff_bc = op_b - op_c;
			abs_bc  = diff_bc[TDBW-1] ? -diff_bc : diff_bc;
			// 16x16 signed product fills the whole lane
			prod_bc = $signed(op_b[DBW-1:0]) * $signed(op_c[DBW-1:0]);
		end

		// Shift amount doubles as the logic sub-function
		always_comb begin
			case (i_ctrl.shamt)
				5'd0:    logic_out = (op_a == '0) ? op_b : op_c;
				5'd2:    logic_out = (op_b > op_c) ? op_b : op_c;
				5'd3:    logic_out = (op_b < op_c) ? op_b : op_c;
				default: logic_out = '0;
			endcase
		end

		always_comb begin
			case (i_ctrl.opcode)
				OP_ADD:   lane_res = op_a + (sum_bc >>> i_ctrl.shamt);
				OP_SUB:   lane_res = op_a + (diff_bc >>> i_ctrl.shamt);
				OP_NORM1: lane_res = op_a + (abs_bc >>> i_ctrl.shamt);
				OP_MAC:   lane_res = op_a + (prod_bc >>> i_ctrl.shamt);
				OP_LOGIC: lane_res = logic_out;
				default:  lane_res = '0;
			endcase
		end

		assign o_result[gi] = lane_res;
	end

endmodule

// File: src/alu_decode.sv
/*
 * Vector ALU decode
 * Finds the SRAM ports an instruction needs and gates the op, SRAM and DRAM handshakes
 */
module alu_decode import alu_isa_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  alu_inst_t i_op,
	input  logic      i_op_rdy,
	output logic      o_op_ack,
	input  logic      i_sramrd0_rdy,
	output logic      o_sramrd0_ack,
	input  logic      i_sramrd1_rdy,
	output logic      o_sramrd1_ack,
	output logic      o_dramwd_rdy,
	input  logic      i_dramwd_ack,
	output alu_ctrl_t o_ctrl,
	output logic      o_commit
);

	logic req_rd0;
	logic req_rd1;
	logic to_dram;
	logic data_ready;

	// ==============================
	// Port requests
	// ==============================

	always_comb begin
		req_rd0 = (i_op.src_a == SRC_SRAM0) || (i_op.src_b == SRC_SRAM0) ||
			(i_op.src_c == SRC_SRAM0);
		req_rd1 = (i_op.src_a == SRC_SRAM1) || (i_op.src_b == SRC_SRAM1) ||
			(i_op.src_c == SRC_SRAM1);
	end

	assign to_dram = i_op.to_dram != 2'd3;

	// Ready once every named SRAM port has its data
	assign data_ready = i_op_rdy && (!req_rd0 || i_sramrd0_rdy) && (!req_rd1 || i_sramrd1_rdy);

	// ==============================
	// Handshakes
	// ==============================

	always_comb begin
		o_dramwd_rdy  = data_ready && to_dram;
		// A DRAM write completes only when the sink takes the word
		o_op_ack      = data_ready && (!to_dram || i_dramwd_ack);
		o_sramrd0_ack = o_op_ack && req_rd0;
		o_sramrd1_ack = o_op_ack && req_rd1;
		o_commit      = o_op_ack;
	end

	always_comb begin
		o_ctrl.opcode    = i_op.opcode;
		o_ctrl.shamt     = i_op.shamt;
		o_ctrl.src_a     = i_op.src_a;
		o_ctrl.src_b     = i_op.src_b;
		o_ctrl.src_c     = i_op.src_c;
		o_ctrl.const_a   = i_op.const_a;
		o_ctrl.const_b   = i_op.const_b;
		o_ctrl.const_c   = i_op.const_c;
		o_ctrl.to_reg    = i_op.to_reg;
		o_ctrl.to_temp   = i_op.to_temp;
		o_ctrl.to_dram   = i_op.to_dram;
		o_ctrl.reg_waddr = i_op.reg_waddr;
	end

endmodule

// File: src/alu_isa_pkg.sv
/*
 * Vector ALU instruction package
 * Opcode and operand source encodings, instruction and control structs
 */
package alu_isa_pkg;

	import alu_data_pkg::*;

	// ==============================
	// Encodings
	// ==============================

	// Codes 2, 5 and 7 are not implemented and give a zero result
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_NORM1 = 3'd3,
		OP_MAC   = 3'd4,
		OP_LOGIC = 3'd6
	} alu_opcode_e;

	typedef enum logic [2:0] {
		SRC_CONST = 3'd0,
		SRC_REG   = 3'd1,
		SRC_SRAM0 = 3'd2,
		SRC_SRAM1 = 3'd3
	} alu_src_e;

	// ==============================
	// Structs
	// ==============================

	// Instruction as issued to the stage
	typedef struct packed {
		alu_opcode_e         opcode;
		logic [4:0]          shamt;
		alu_src_e            src_a;
		alu_src_e            src_b;
		alu_src_e            src_c;
		lane_t               const_a;
		lane_t               const_b;
		lane_t               const_c;
		logic                to_reg;
		logic                to_temp;
		logic [1:0]          to_dram;   // 3 means no DRAM write
		logic [SRAM_ABW-1:0] reg_waddr;
	} alu_inst_t;

	// Fields consumed by execute and result
	typedef struct packed {
		alu_opcode_e         opcode;
		logic [4:0]          shamt;
		alu_src_e            src_a;
		alu_src_e            src_b;
		alu_src_e            src_c;
		lane_t               const_a;
		lane_t               const_b;
		lane_t               const_c;
		logic                to_reg;
		logic                to_temp;
		logic [1:0]          to_dram;
		logic [SRAM_ABW-1:0] reg_waddr;
	} alu_ctrl_t;

endpackage

// File: src/alu_data_pkg.sv
/*
 * Vector ALU data-path package
 * Lane and memory word widths and their value types
 */
package alu_data_pkg;

	// ==============================
	// Widths
	// ==============================

	// SRAM and DRAM word width
	localparam int DBW = 16;

	// Working lane width inside the ALU
	localparam int TDBW = 32;

	// Register file write address width
	localparam int SRAM_ABW = 8;

	// ==============================
	// Value types
	// ==============================

	typedef logic signed [TDBW-1:0] lane_t;

	// Raw memory word, sign is applied when it enters a lane
	typedef logic [DBW-1:0] sram_word_t;

endpackage
